/* verilog/renamePkg.sv */
package renamePkg;

  // reorder buffer depth, one slot always stays empty
  localparam int numRob = 8;

  // architectural register file size
  localparam int numArch = 8;

  // one tag per register plus one per in-flight instruction,
  // so the free list cannot run dry while the buffer has room
  localparam int numPhys = numArch + numRob;

  // index widths
  localparam int robIdxW = $clog2(numRob);
  localparam int archRegW = $clog2(numArch);
  localparam int physTagW = $clog2(numPhys);
  localparam int freePtrW = $clog2(numPhys);

  // reorder buffer slot index
  typedef logic [robIdxW-1:0] robIdxT;

  // architectural register number
  typedef logic [archRegW-1:0] archRegT;

  // physical register tag
  typedef logic [physTagW-1:0] physTagT;

  // free list ring pointer, wraps naturally
  typedef logic [freePtrW-1:0] freePtrT;

  // reset state:
  // architectural register r maps to tag r,
  // tags numArch .. numPhys-1 start out free in ascending order

endpackage

/* verilog/reorderBuffer.sv */
`timescale 1ns/1ps

module reorderBuffer
  import renamePkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    dispatchFire,
  input  logic    retireFire,
  input  logic    squash,
  input  archRegT destReg,
  input  logic    halt,
  input  physTagT physTag,
  input  physTagT oldPhysTag,
  input  logic    completeEn,
  input  robIdxT  completeIdx,
  input  robIdxT  rollbackIdx,
  output robIdxT  robIdx,
  output robIdxT  headIdx,
  output logic    robFull,
  output logic    headReady,
  output logic    rollbackHit,
  output archRegT retireDest,
  output physTagT retireTag,
  output physTagT retireOldTag,
  output logic    halted
);

  // per-entry status bits
  logic [numRob-1:0] entryValid;
  logic [numRob-1:0] entryComplete;

  // per-entry payload
  logic [numRob-1:0] entryHalt;
  archRegT entryDest [numRob];
  physTagT entryTag [numRob];
  physTagT entryOldTag [numRob];

  // oldest entry and next free slot
  robIdxT head;
  robIdxT tail;

  // squash bookkeeping
  robIdxT squashSpan;
  robIdxT offset [numRob];
  logic [numRob-1:0] killMask;

  // new instruction lands at the tail
  assign robIdx = tail;
  assign headIdx = head;

  // one slot kept empty so full and empty differ
  assign robFull = (robIdxT'(tail + 1'b1) == head);

  assign headReady = entryValid[head] && entryComplete[head];
  assign rollbackHit = entryValid[rollbackIdx];

  // retire data straight from the head entry
  assign retireDest = entryDest[head];
  assign retireTag = entryTag[head];
  assign retireOldTag = entryOldTag[head];
  assign halted = retireFire && entryHalt[head];

  // distance from the branch to the old tail
  assign squashSpan = tail - rollbackIdx;

  // kill everything strictly younger than the branch, wrapping around
  always_comb begin
    for (int i = 0; i < numRob; i++) begin
      offset[i] = robIdxT'(i) - rollbackIdx;
      killMask[i] = (offset[i] != '0) && (offset[i] < squashSpan);
    end
  end

  // pointers and status bits
  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      entryValid <= '0;
      entryComplete <= '0;
    end else begin
      // completion by index from the execution side
      if (completeEn) begin
        entryComplete[completeIdx] <= 1'b1;
      end
      if (dispatchFire) begin
        entryValid[tail] <= 1'b1;
        entryComplete[tail] <= 1'b0;
        tail <= tail + 1'b1;
      end
      if (retireFire) begin
        entryValid[head] <= 1'b0;
        head <= head + 1'b1;
      end
      // dispatch is blocked while rolling back, so the tail has one writer
      if (squash) begin
        for (int i = 0; i < numRob; i++) begin
          if (killMask[i]) begin
            entryValid[i] <= 1'b0;
          end
        end
        tail <= rollbackIdx + 1'b1;
      end
    end
  end

  // payload written at dispatch
  always_ff @(posedge clock) begin
    if (dispatchFire) begin
      entryDest[tail] <= destReg;
      entryTag[tail] <= physTag;
      entryOldTag[tail] <= oldPhysTag;
      entryHalt[tail] <= halt;
    end
  end

endmodule

/* verilog/freeList.sv */
`timescale 1ns/1ps

module freeList
  import renamePkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    dispatchFire,
  input  logic    retireFire,
  input  logic    recover,
  input  physTagT retireOldTag,
  output physTagT physTag
);

  // ring of free tags
  physTagT ring [numPhys];

  // speculative head, tail, and committed head
  freePtrT readPtr;
  freePtrT writePtr;
  freePtrT archReadPtr;
  freePtrT archReadNext;

  // next tag to hand out
  assign physTag = ring[readPtr];

  // every retire commits one allocation, since every instruction allocates
  assign archReadNext = retireFire ? freePtrT'(archReadPtr + 1'b1) : archReadPtr;

  // ring contents
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < numRob; i++) begin
        ring[i] <= physTagT'(numArch + i);
      end
    end else if (retireFire) begin
      // freed tag goes in behind the last free one
      ring[writePtr] <= retireOldTag;
    end
  end

  // pointers
  always_ff @(posedge clock) begin
    if (reset) begin
      readPtr <= '0;
      writePtr <= freePtrT'(numRob);
      archReadPtr <= '0;
    end else begin
      archReadPtr <= archReadNext;
      if (retireFire) begin
        writePtr <= writePtr + 1'b1;
      end
      // recover comes with the branch retire, so take the updated pointer
      if (recover) begin
        readPtr <= archReadNext;
      end else if (dispatchFire) begin
        readPtr <= readPtr + 1'b1;
      end
    end
  end

  // squashed allocations sit between archReadPtr and readPtr; writePtr
  // stays numRob ahead of archReadPtr so they are never overwritten

endmodule

/* verilog/mapTable.sv */
`timescale 1ns/1ps

module mapTable
  import renamePkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    dispatchFire,
  input  archRegT destReg,
  input  physTagT physTag,
  input  logic    recover,
  input  physTagT archMap [numArch],
  output physTagT oldPhysTag
);

  // speculative mapping, one tag per architectural register
  physTagT specMap [numArch];

  // previous mapping of the destination, read in the dispatch cycle
  assign oldPhysTag = specMap[destReg];

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity mapping out of reset
      for (int r = 0; r < numArch; r++) begin
        specMap[r] <= physTagT'(r);
      end
    end else if (recover) begin
      // throw away the speculative state
      for (int r = 0; r < numArch; r++) begin
        specMap[r] <= archMap[r];
      end
    end else if (dispatchFire) begin
      specMap[destReg] <= physTag;
    end
  end

endmodule

/* verilog/archMapTable.sv */
`timescale 1ns/1ps

module archMapTable
  import renamePkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    retireFire,
  input  archRegT retireDest,
  input  physTagT retireTag,
  output physTagT archMap [numArch]
);

  // committed mapping
  physTagT committed [numArch];

  // recovery happens on the branch's own retire,
  // so the retiring write is forwarded into the view
  always_comb begin
    for (int r = 0; r < numArch; r++) begin
      if (retireFire && (retireDest == archRegT'(r))) begin
        archMap[r] = retireTag;
      end else begin
        archMap[r] = committed[r];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < numArch; r++) begin
        committed[r] <= physTagT'(r);
      end
    end else if (retireFire) begin
      committed[retireDest] <= retireTag;
    end
  end

endmodule

/* verilog/renameControl.sv */
`timescale 1ns/1ps

module renameControl
  import renamePkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  logic   dispatchEn,
  input  logic   rollbackEn,
  input  robIdxT rollbackIdx,
  input  logic   robFull,
  input  logic   headReady,
  input  robIdxT headIdx,
  input  logic   rollbackHit,
  output logic   dispatchReady,
  output logic   dispatchFire,
  output logic   retireFire,
  output logic   squash,
  output logic   recover
);

  typedef enum logic {
    idle,
    draining
  } stateT;

  stateT state;

  // branch we are waiting on
  robIdxT branchIdx;

  // no dispatch while draining or with seven in flight
  assign dispatchReady = (state == idle) && !robFull;
  assign dispatchFire = dispatchEn && dispatchReady && !rollbackEn;

  // no retire stall
  assign retireFire = headReady;

  // rollback of an empty slot is ignored
  assign squash = rollbackEn && rollbackHit;

  // branch reaches the head and retires, state is architectural again
  assign recover = retireFire && (state == draining) && (headIdx == branchIdx);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
      branchIdx <= '0;
    end else if (recover) begin
      // a squash now can only hit the retiring branch itself
      state <= idle;
    end else if (squash) begin
      state <= draining;
      branchIdx <= rollbackIdx;
    end
  end

endmodule

/* verilog/renameCore.sv */
`timescale 1ns/1ps

module renameCore
  import renamePkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    dispatchEn,
  input  archRegT destReg,
  input  logic    halt,
  input  logic    completeEn,
  input  robIdxT  completeIdx,
  input  logic    rollbackEn,
  input  robIdxT  rollbackIdx,
  output logic    dispatchReady,
  output robIdxT  robIdx,
  output physTagT physTag,
  output physTagT oldPhysTag,
  output logic    retireValid,
  output archRegT retireDest,
  output physTagT retireTag,
  output physTagT retireOldTag,
  output logic    halted
);

  // control strobes
  logic dispatchFire;
  logic squash;
  logic recover;

  // buffer status back to control
  logic robFull;
  logic headReady;
  logic rollbackHit;
  robIdxT headIdx;

  // committed map, source for recovery
  physTagT archMap [numArch];

  // retireValid doubles as the retire strobe
  renameControl control (
    .clock(clock),
    .reset(reset),
    .dispatchEn(dispatchEn),
    .rollbackEn(rollbackEn),
    .rollbackIdx(rollbackIdx),
    .robFull(robFull),
    .headReady(headReady),
    .headIdx(headIdx),
    .rollbackHit(rollbackHit),
    .dispatchReady(dispatchReady),
    .dispatchFire(dispatchFire),
    .retireFire(retireValid),
    .squash(squash),
    .recover(recover)
  );

  reorderBuffer rob (
    .clock(clock),
    .reset(reset),
    .dispatchFire(dispatchFire),
    .retireFire(retireValid),
    .squash(squash),
    .destReg(destReg),
    .halt(halt),
    .physTag(physTag),
    .oldPhysTag(oldPhysTag),
    .completeEn(completeEn),
    .completeIdx(completeIdx),
    .rollbackIdx(rollbackIdx),
    .robIdx(robIdx),
    .headIdx(headIdx),
    .robFull(robFull),
    .headReady(headReady),
    .rollbackHit(rollbackHit),
    .retireDest(retireDest),
    .retireTag(retireTag),
    .retireOldTag(retireOldTag),
    .halted(halted)
  );

  freeList freeTags (
    .clock(clock),
    .reset(reset),
    .dispatchFire(dispatchFire),
    .retireFire(retireValid),
    .recover(recover),
    .retireOldTag(retireOldTag),
    .physTag(physTag)
  );

  mapTable specMap (
    .clock(clock),
    .reset(reset),
    .dispatchFire(dispatchFire),
    .destReg(destReg),
    .physTag(physTag),
    .recover(recover),
    .archMap(archMap),
    .oldPhysTag(oldPhysTag)
  );

  archMapTable commitMap (
    .clock(clock),
    .reset(reset),
    .retireFire(retireValid),
    .retireDest(retireDest),
    .retireTag(retireTag),
    .archMap(archMap)
  );

endmodule

/* dv/renameCore_assertions.sv */
`timescale 1ns/1ps

module renameCore_assertions
  import renamePkg::*;
(
  input logic    clock,
  input logic    reset,
  input logic    dispatchEn,
  input archRegT destReg,
  input logic    halt,
  input logic    completeEn,
  input robIdxT  completeIdx,
  input logic    rollbackEn,
  input robIdxT  rollbackIdx,
  input logic    dispatchReady,
  input robIdxT  robIdx,
  input physTagT physTag,
  input physTagT oldPhysTag,
  input logic    retireValid,
  input archRegT retireDest,
  input physTagT retireTag,
  input physTagT retireOldTag,
  input logic    halted
);

  // failed checks so far
  int failures = 0;

  // in-flight instructions in program order by buffer slot
  archRegT qDest [numRob];
  physTagT qTag [numRob];
  physTagT qOld [numRob];
  logic [numRob-1:0] qHalt;
  logic [numRob-1:0] qDone;
  robIdxT qHead;
  robIdxT qTail;

  // free tags with the next one to hand out at freeHead
  physTagT freeQ [numPhys];
  freePtrT freeHead;
  freePtrT freeTail;

  // reference register maps
  physTagT specMap [numArch];
  physTagT archMap [numArch];
  logic draining;
  robIdxT branch;

  robIdxT inFlight;
  robIdxT squashed;
  logic take;
  logic hit;
  logic expReady;
  logic expRetire;
  logic expRecover;
  logic expHalted;
  physTagT expTag;
  physTagT expOld;
  archRegT headDest;
  physTagT headTag;
  physTagT headOld;

  // never more than seven in flight, so the 3-bit difference is exact
  assign inFlight = qTail - qHead;
  assign expReady = !draining && (inFlight != robIdxT'(numRob - 1));
  assign take = dispatchEn && expReady && !rollbackEn;
  assign expRetire = (inFlight != '0) && qDone[qHead];
  assign hit = rollbackEn && (robIdxT'(rollbackIdx - qHead) < inFlight);
  assign squashed = qTail - rollbackIdx - 1'b1;
  assign expRecover = expRetire && draining && (qHead == branch);
  assign expHalted = expRetire && qHalt[qHead];
  assign expTag = freeQ[freeHead];
  assign expOld = specMap[destReg];
  assign headDest = qDest[qHead];
  assign headTag = qTag[qHead];
  assign headOld = qOld[qHead];

  always_ff @(posedge clock) begin
    if (reset) begin
      qHead <= '0;
      qTail <= '0;
      qDone <= '0;
      draining <= 1'b0;
      branch <= '0;
      freeHead <= '0;
      freeTail <= freePtrT'(numRob);
      for (int r = 0; r < numArch; r++) begin
        specMap[r] <= physTagT'(r);
        archMap[r] <= physTagT'(r);
      end
      for (int i = 0; i < numRob; i++) begin
        freeQ[i] <= physTagT'(numArch + i);
      end
    end else begin
      if (completeEn) begin
        qDone[completeIdx] <= 1'b1;
      end
      if (take) begin
        qDest[qTail] <= destReg;
        qTag[qTail] <= expTag;
        qOld[qTail] <= expOld;
        qHalt[qTail] <= halt;
        qDone[qTail] <= 1'b0;
        qTail <= qTail + 1'b1;
        freeHead <= freeHead + 1'b1;
        specMap[destReg] <= expTag;
      end
      if (expRetire) begin
        archMap[headDest] <= headTag;
        freeQ[freeTail] <= headOld;
        freeTail <= freeTail + 1'b1;
        qHead <= qHead + 1'b1;
      end
      if (expRecover) begin
        // branch retires and the speculative map falls back to the committed one
        draining <= 1'b0;
        for (int r = 0; r < numArch; r++) begin
          specMap[r] <= (archRegT'(r) == headDest) ? headTag : archMap[r];
        end
      end else if (hit) begin
        draining <= 1'b1;
        branch <= rollbackIdx;
        qTail <= rollbackIdx + 1'b1;
        // squashed tags are handed out again, oldest first
        freeHead <= freeHead - squashed;
      end
    end
  end

  afterReset: assert property (@(posedge clock)
    reset |=> !retireValid && !halted && dispatchReady)
    else begin
      failures++;
      $error("mismatch afterReset expected %b actual %b", 3'b001,
        $sampled({retireValid, halted, dispatchReady}));
    end

  readyCheck: assert property (@(posedge clock) disable iff (reset)
    dispatchReady == expReady)
    else begin
      failures++;
      $error("mismatch readyCheck expected %0d actual %0d",
        $sampled(expReady), $sampled(dispatchReady));
    end

  robIdxCheck: assert property (@(posedge clock) disable iff (reset)
    take |-> robIdx == qTail)
    else begin
      failures++;
      $error("mismatch robIdxCheck expected %0d actual %0d", $sampled(qTail), $sampled(robIdx));
    end

  tagCheck: assert property (@(posedge clock) disable iff (reset)
    take |-> physTag == expTag)
    else begin
      failures++;
      $error("mismatch tagCheck expected %0d actual %0d", $sampled(expTag), $sampled(physTag));
    end

  oldTagCheck: assert property (@(posedge clock) disable iff (reset)
    take |-> oldPhysTag == expOld)
    else begin
      failures++;
      $error("mismatch oldTagCheck expected %0d actual %0d",
        $sampled(expOld), $sampled(oldPhysTag));
    end

  retireCheck: assert property (@(posedge clock) disable iff (reset)
    retireValid == expRetire)
    else begin
      failures++;
      $error("mismatch retireCheck expected %0d actual %0d",
        $sampled(expRetire), $sampled(retireValid));
    end

  retireDestCheck: assert property (@(posedge clock) disable iff (reset)
    expRetire |-> retireDest == headDest)
    else begin
      failures++;
      $error("mismatch retireDestCheck expected %0d actual %0d",
        $sampled(headDest), $sampled(retireDest));
    end

  retireTagCheck: assert property (@(posedge clock) disable iff (reset)
    expRetire |-> retireTag == headTag)
    else begin
      failures++;
      $error("mismatch retireTagCheck expected %0d actual %0d",
        $sampled(headTag), $sampled(retireTag));
    end

  retireOldCheck: assert property (@(posedge clock) disable iff (reset)
    expRetire |-> retireOldTag == headOld)
    else begin
      failures++;
      $error("mismatch retireOldCheck expected %0d actual %0d",
        $sampled(headOld), $sampled(retireOldTag));
    end

  // halted only in the retire cycle of a halt entry
  haltCheck: assert property (@(posedge clock) disable iff (reset)
    halted == expHalted)
    else begin
      failures++;
      $error("mismatch haltCheck expected %0d actual %0d", $sampled(expHalted), $sampled(halted));
    end

endmodule

bind renameCore renameCore_assertions checks (.*);

/* dv/renameCoreTb.sv */
`timescale 1ns/1ps

module renameCoreTb
  import renamePkg::*;
();

  logic clock;
  logic reset;
  logic dispatchEn;
  archRegT destReg;
  logic halt;
  logic completeEn;
  robIdxT completeIdx;
  logic rollbackEn;
  robIdxT rollbackIdx;
  logic dispatchReady;
  robIdxT robIdx;
  physTagT physTag;
  physTagT oldPhysTag;
  logic retireValid;
  archRegT retireDest;
  physTagT retireTag;
  physTagT retireOldTag;
  logic halted;

  logic [31:0] lfsr = 32'h6978;
  int cycles = 0;

  // dispatched and not yet completed entries in program order
  robIdxT pending [$];

  // instruction waiting for dispatchReady
  logic held;
  archRegT heldDest;
  logic heldHalt;
  logic sawRetire;

  renameCore dut (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // run limit is more than twice the stimulus length
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (dut.checks.failures != 0) begin
      $display("TB FAILED");
      $fatal(1, "a rename check failed, see the error above");
    end else if (cycles >= 600) begin
      $display("TB FAILED");
      $fatal(1, "run did not finish within %0d cycles", cycles);
    end
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic takeBits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  // one clock of dispatch and completion traffic
  task automatic driveCycle(input logic tryDispatch, input logic tryComplete);
    int r;
    int pick;
    if (tryDispatch && !held) begin
      takeBits(3, r);
      heldDest = archRegT'(r);
      takeBits(3, r);
      heldHalt = (r == 0);
      held = 1'b1;
    end
    dispatchEn = tryDispatch;
    destReg = heldDest;
    halt = heldHalt;
    completeEn = 1'b0;
    if (tryComplete && pending.size() > 0) begin
      takeBits(3, r);
      pick = r % pending.size();
      completeEn = 1'b1;
      completeIdx = pending[pick];
      pending.delete(pick);
    end
    // everything combinational has settled by mid-cycle
    @(negedge clock);
    sawRetire = retireValid;
    if (dispatchEn && dispatchReady) begin
      pending.push_back(robIdx);
      held = 1'b0;
    end
    @(posedge clock);
    #1;
    dispatchEn = 1'b0;
    completeEn = 1'b0;
  endtask

  // roll back to an incomplete entry that has younger ones behind it
  task automatic rollBack();
    int r;
    int pos;
    if (pending.size() > 1) begin
      takeBits(2, r);
      pos = r % (pending.size() - 1);
      rollbackEn = 1'b1;
      rollbackIdx = pending[pos];
      @(posedge clock);
      #1;
      rollbackEn = 1'b0;
      while (pending.size() > pos + 1) begin
        void'(pending.pop_back());
      end
    end
  endtask

  // complete the rest and wait until retirement stops
  task automatic drainAll();
    while (pending.size() > 0) begin
      driveCycle(1'b0, 1'b1);
    end
    driveCycle(1'b0, 1'b0);
    while (sawRetire) begin
      driveCycle(1'b0, 1'b0);
    end
  endtask

  initial begin
    int r;
    int c;
    reset = 1'b1;
    dispatchEn = 1'b0;
    destReg = '0;
    halt = 1'b0;
    completeEn = 1'b0;
    completeIdx = '0;
    rollbackEn = 1'b0;
    rollbackIdx = '0;
    held = 1'b0;
    heldDest = '0;
    heldHalt = 1'b0;
    sawRetire = 1'b0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;

    // fill past seven in flight with nothing complete
    repeat (9) driveCycle(1'b1, 1'b0);
    // out-of-order completion while dispatch keeps trying
    repeat (12) driveCycle(1'b1, 1'b1);
    // mixed traffic
    repeat (120) begin
      takeBits(2, r);
      takeBits(1, c);
      driveCycle(r != 0, c != 0);
    end
    // rollbacks with a drain after each
    repeat (3) begin
      repeat (5) driveCycle(1'b1, 1'b0);
      rollBack();
      repeat (25) driveCycle(1'b1, 1'b1);
    end
    drainAll();
    repeat (2) @(posedge clock);

    if (dut.checks.failures == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("TB FAILED");
      $fatal(1, "rename checks reported failures");
    end
  end

endmodule

/* all.f */
verilog/renamePkg.sv
verilog/reorderBuffer.sv
verilog/freeList.sv
verilog/mapTable.sv
verilog/archMapTable.sv
verilog/renameControl.sv
verilog/renameCore.sv
dv/renameCore_assertions.sv
dv/renameCoreTb.sv
